// ==== hdl/sys1_pkg.sv ====
// System 1 main board shared types, bus bundles and fixed address constants
`default_nettype none

package sys1_pkg;

	// Widths with a meaning on the board
	typedef logic [7:0] byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [17:0] dl_addr_t;

	// CPU bus, address and write data plus the level controls
	typedef struct packed {
		cpu_addr_t addr;
		byte_t dout;
		logic mreq;
		logic iorq;
		logic rd;
		logic wr;
	} cpu_bus_t;

	// Region selects from the bus decoder
	typedef struct packed {
		logic vid;
		logic vidm;
		logic port;
		logic ram;
		logic rom0;
		logic rom1;
		logic sreq;
	} bus_sel_t;

	// Player inputs and DIP switches
	typedef struct packed {
		byte_t inp0;
		byte_t inp1;
		byte_t inp2;
		byte_t dsw0;
		byte_t dsw1;
	} inputs_t;

	// Low I/O addresses, each register is mirrored at two places
	localparam byte_t IO_SREQ_A = 8'h14;
	localparam byte_t IO_SREQ_B = 8'h18;
	localparam byte_t IO_VIDM_A = 8'h15;
	localparam byte_t IO_VIDM_B = 8'h19;

	// Banked ROM window in the download address space
	localparam dl_addr_t DL_ROM1_BASE = 18'h08000;
	localparam dl_addr_t DL_ROM1_SIZE = 18'h04000;

endpackage

`default_nettype wire

// ==== hdl/main_bus_decoder.sv ====
// Main CPU bus decoder, CPU clock enable divider, region selects and write strobes
`timescale 1ns/10ps
`default_nettype none

module main_bus_decoder #(
	parameter int CE_DIV_LOG2 = 4,
	parameter int RAM_AW = 12
) (
	input wire CLK48M,
	input wire RESET,
	input wire sys1_pkg::cpu_bus_t cpu_bus,
	input wire vid_cs,
	output logic cpu_ce,
	output sys1_pkg::bus_sel_t sel,
	output logic ram_we,
	output logic vidm_we,
	output logic sreq_we,
	output logic cpu_wr_out
);

	import sys1_pkg::*;

	// Work RAM sits at 0xC000, its size follows RAM_AW
	localparam cpu_addr_t RAM_BASE = 16'hC000;

	logic [CE_DIV_LOG2-1:0] ce_cnt;
	byte_t io_addr;
	logic cpu_wr_ok;

	// Free running divider, one enable at the end of each count
	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			ce_cnt <= '0;
			cpu_ce <= 1'b0;
		end else begin
			ce_cnt <= ce_cnt + 1'b1;
			cpu_ce <= &ce_cnt;
		end
	end

	assign io_addr = cpu_bus.addr[7:0];

	// Memory and I/O regions
	always_comb begin
		sel.vid = vid_cs;
		sel.vidm = cpu_bus.iorq & ((io_addr == IO_VIDM_A) | (io_addr == IO_VIDM_B));
		sel.sreq = cpu_bus.iorq & ((io_addr == IO_SREQ_A) | (io_addr == IO_SREQ_B));
		// Port mux does the fine decode
		sel.port = cpu_bus.iorq & cpu_bus.rd;
		sel.rom0 = cpu_bus.mreq & (cpu_bus.addr[15] == 1'b0);
		sel.rom1 = cpu_bus.mreq & (cpu_bus.addr[15:14] == 2'b10);
		sel.ram = cpu_bus.mreq & (cpu_bus.addr[15:RAM_AW] == RAM_BASE[15:RAM_AW]);
	end

	// Memory write qualifier for the board
	assign cpu_wr_out = cpu_bus.wr & cpu_bus.mreq;

	// A write lands only on the enable edge
	assign cpu_wr_ok = cpu_bus.wr & cpu_ce;

	assign ram_we = cpu_wr_ok & sel.ram;
	assign vidm_we = cpu_wr_ok & sel.vidm;
	assign sreq_we = cpu_wr_ok & sel.sreq;

endmodule

`default_nettype wire

// ==== hdl/input_port_mux.sv ====
// Input port decode, picks a player input or DIP switch byte for I/O reads
`timescale 1ns/10ps
`default_nettype none

module input_port_mux (
	input wire sys1_pkg::cpu_bus_t cpu_bus,
	input wire sys1_pkg::inputs_t board_in,
	output logic port_hit,
	output sys1_pkg::byte_t port_do
);

	logic [2:0] port_no;
	logic cs_inp0;
	logic cs_inp1;
	logic cs_inp2;
	logic cs_dsw0;
	logic cs_dsw1;

	assign port_no = cpu_bus.addr[4:2];

	// Port 3 is split by address bit 0, port 4 is a DSW1 mirror
	assign cs_inp0 = cpu_bus.iorq & (port_no == 3'd0);
	assign cs_inp1 = cpu_bus.iorq & (port_no == 3'd1);
	assign cs_inp2 = cpu_bus.iorq & (port_no == 3'd2);
	assign cs_dsw0 = cpu_bus.iorq & (port_no == 3'd3) & ~cpu_bus.addr[0];
	assign cs_dsw1 = cpu_bus.iorq & (((port_no == 3'd3) & cpu_bus.addr[0]) | (port_no == 3'd4));

	assign port_hit = cs_inp0 | cs_inp1 | cs_inp2 | cs_dsw0 | cs_dsw1;

	always_comb begin
		if (cs_inp0) begin
			port_do = board_in.inp0;
		end else if (cs_inp1) begin
			port_do = board_in.inp1;
		end else if (cs_inp2) begin
			port_do = board_in.inp2;
		end else if (cs_dsw0) begin
			port_do = board_in.dsw0;
		end else if (cs_dsw1) begin
			port_do = board_in.dsw1;
		end else begin
			port_do = 8'hFF;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/work_ram.sv ====
// Main CPU work RAM, single port with synchronous read
`timescale 1ns/10ps
`default_nettype none

module work_ram #(
	parameter int RAM_AW = 12
) (
	input wire CLK48M,
	input wire [RAM_AW-1:0] addr,
	input wire we,
	input wire sys1_pkg::byte_t din,
	output sys1_pkg::byte_t dout
);

	logic [7:0] mem [0:(1 << RAM_AW) - 1];

	// Read returns the contents from before a write on the same edge
	always_ff @(posedge CLK48M) begin
		if (we) begin
			mem[addr] <= din;
		end
		dout <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== hdl/download_rom.sv ====
// Banked 16 KB program ROM, loaded from the download port and read by the CPU
`timescale 1ns/10ps
`default_nettype none

module download_rom (
	input wire CLK48M,
	input wire [13:0] rd_addr,
	input wire sys1_pkg::dl_addr_t dl_addr,
	input wire sys1_pkg::byte_t dl_data,
	input wire dl_wr,
	output sys1_pkg::byte_t rd_data
);

	import sys1_pkg::*;

	byte_t mem [0:(1 << 14) - 1];
	logic dl_hit;
	dl_addr_t dl_offset;

	// Only the rom1 slice of the download stream lands here
	assign dl_hit = (dl_addr >= DL_ROM1_BASE) & (dl_addr < (DL_ROM1_BASE + DL_ROM1_SIZE));
	assign dl_offset = dl_addr - DL_ROM1_BASE;

	always_ff @(posedge CLK48M) begin
		if (dl_wr & dl_hit) begin
			mem[dl_offset[13:0]] <= dl_data;
		end
	end

	// CPU side read port
	always_ff @(posedge CLK48M) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/io_latches.sv ====
// Video mode latch and sound command register with a single cycle request
`timescale 1ns/10ps
`default_nettype none

module io_latches (
	input wire CLK48M,
	input wire RESET,
	input wire sys1_pkg::byte_t din,
	input wire vidm_we,
	input wire sreq_we,
	output sys1_pkg::byte_t vid_mode,
	output sys1_pkg::byte_t snd_no,
	output logic snd_rq
);

	// Video mode
	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			vid_mode <= '0;
		end else if (vidm_we) begin
			vid_mode <= din;
		end
	end

	// Command byte held until the next sound write
	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			snd_no <= '0;
		end else if (sreq_we) begin
			snd_no <= din;
		end
	end

	// Strobe is already one cycle wide, so the request is too
	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			snd_rq <= 1'b0;
		end else begin
			snd_rq <= sreq_we;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_data_select.sv ====
// CPU read data selector with fixed priority and open bus default, registered
`timescale 1ns/10ps
`default_nettype none

module cpu_data_select (
	input wire CLK48M,
	input wire RESET,
	input wire sys1_pkg::bus_sel_t sel,
	input wire port_hit,
	input wire sys1_pkg::byte_t vid_do,
	input wire sys1_pkg::byte_t vid_mode,
	input wire sys1_pkg::byte_t port_do,
	input wire sys1_pkg::byte_t ram_do,
	input wire sys1_pkg::byte_t rom0_do,
	input wire sys1_pkg::byte_t rom1_do,
	output sys1_pkg::byte_t cpu_di
);

	import sys1_pkg::*;

	byte_t di_next;

	// Highest priority first
	always_comb begin
		if (sel.vid) begin
			di_next = vid_do;
		end else if (sel.vidm) begin
			di_next = vid_mode;
		end else if (sel.port & port_hit) begin
			di_next = port_do;
		end else if (sel.ram) begin
			di_next = ram_do;
		end else if (sel.rom0) begin
			di_next = rom0_do;
		end else if (sel.rom1) begin
			di_next = rom1_do;
		end else begin
			// Open bus
			di_next = 8'hFF;
		end
	end

	always_ff @(posedge CLK48M or posedge RESET) begin
		if (RESET) begin
			cpu_di <= 8'hFF;
		end else begin
			cpu_di <= di_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sys1_main_top.sv ====
// System 1 main CPU board top, connects bus decode, memories, latches and read mux
`timescale 1ns/10ps
`default_nettype none

module sys1_main_top #(
	parameter int CE_DIV_LOG2 = 4,
	parameter int RAM_AW = 12
) (
	input wire CLK48M,
	input wire RESET,

	// CPU side
	input wire sys1_pkg::cpu_bus_t cpu_bus,
	output wire cpu_ce,
	output wire sys1_pkg::byte_t cpu_di,
	output wire cpu_wr_out,

	// Board inputs and video window
	input wire sys1_pkg::inputs_t board_in,
	input wire vid_cs,
	input wire sys1_pkg::byte_t vid_do,
	output wire sys1_pkg::byte_t vid_mode,

	// External program ROM
	output wire [14:0] cpu_rom_addr,
	input wire sys1_pkg::byte_t cpu_rom_do,

	// ROM download port
	input wire sys1_pkg::dl_addr_t dl_addr,
	input wire sys1_pkg::byte_t dl_data,
	input wire dl_wr,

	// Sound board command
	output wire snd_rq,
	output wire sys1_pkg::byte_t snd_no
);

	import sys1_pkg::*;

	bus_sel_t sel;
	wire ram_we;
	wire vidm_we;
	wire sreq_we;
	wire port_hit;
	byte_t port_do;
	byte_t ram_do;
	byte_t rom1_do;

	// Program ROM sees the low 32 KB directly
	assign cpu_rom_addr = cpu_bus.addr[14:0];

	main_bus_decoder #(
		.CE_DIV_LOG2(CE_DIV_LOG2),
		.RAM_AW(RAM_AW)
	) u_decoder (
		.CLK48M(CLK48M),
		.RESET(RESET),
		.cpu_bus(cpu_bus),
		.vid_cs(vid_cs),
		.cpu_ce(cpu_ce),
		.sel(sel),
		.ram_we(ram_we),
		.vidm_we(vidm_we),
		.sreq_we(sreq_we),
		.cpu_wr_out(cpu_wr_out)
	);

	input_port_mux u_ports (
		.cpu_bus(cpu_bus),
		.board_in(board_in),
		.port_hit(port_hit),
		.port_do(port_do)
	);

	work_ram #(
		.RAM_AW(RAM_AW)
	) u_ram (
		.CLK48M(CLK48M),
		.addr(cpu_bus.addr[RAM_AW-1:0]),
		.we(ram_we),
		.din(cpu_bus.dout),
		.dout(ram_do)
	);

	download_rom u_rom1 (
		.CLK48M(CLK48M),
		.rd_addr(cpu_bus.addr[13:0]),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.dl_wr(dl_wr),
		.rd_data(rom1_do)
	);

	io_latches u_latches (
		.CLK48M(CLK48M),
		.RESET(RESET),
		.din(cpu_bus.dout),
		.vidm_we(vidm_we),
		.sreq_we(sreq_we),
		.vid_mode(vid_mode),
		.snd_no(snd_no),
		.snd_rq(snd_rq)
	);

	cpu_data_select u_data_sel (
		.CLK48M(CLK48M),
		.RESET(RESET),
		.sel(sel),
		.port_hit(port_hit),
		.vid_do(vid_do),
		.vid_mode(vid_mode),
		.port_do(port_do),
		.ram_do(ram_do),
		.rom0_do(cpu_rom_do),
		.rom1_do(rom1_do),
		.cpu_di(cpu_di)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source, 10 ns clock with reset held for three cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic CLK48M,
	output logic RESET
);

	initial begin
		CLK48M = 1'b0;
		forever #5 CLK48M = ~CLK48M;
	end

	initial begin
		RESET = 1'b1;
		repeat (3) @(posedge CLK48M);
		#1 RESET = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb/sys1_main_tb.sv ====
// System 1 main board testbench, plays the CPU and checks reads, writes and latches
`timescale 1ns/10ps
`default_nettype none

module sys1_main_tb;

	import sys1_pkg::*;

	localparam int N_BUS_CYCLES = 400;
	localparam int DL_CYCLES = 16386;
	localparam int TIMEOUT_NS = (N_BUS_CYCLES * 16 + DL_CYCLES + 1000) * 10;

	logic CLK48M;
	logic RESET;
	cpu_bus_t cpu_bus;
	inputs_t board_in;
	logic vid_cs;
	byte_t vid_do;
	byte_t cpu_rom_do;
	dl_addr_t dl_addr;
	byte_t dl_data;
	logic dl_wr;
	logic cpu_ce;
	byte_t cpu_di;
	logic cpu_wr_out;
	logic [14:0] cpu_rom_addr;
	byte_t vid_mode;
	logic snd_rq;
	byte_t snd_no;

	// Reference state
	logic [15:0] lfsr_state = 16'd27079;
	byte_t ram_model [0:4095];
	byte_t rom1_model [0:16383];
	cpu_addr_t ram_written [$];
	int rq_seen = 0;
	int rq_expected = 0;
	int ce_gap = 0;
	logic ce_seen = 1'b0;
	logic rq_prev = 1'b0;

	tb_clock_gen u_clk (.CLK48M(CLK48M), .RESET(RESET));

	sys1_main_top #(.CE_DIV_LOG2(4), .RAM_AW(12)) UUT (
		.CLK48M(CLK48M), .RESET(RESET), .cpu_bus(cpu_bus), .cpu_ce(cpu_ce),
		.cpu_di(cpu_di), .cpu_wr_out(cpu_wr_out), .board_in(board_in),
		.vid_cs(vid_cs), .vid_do(vid_do), .vid_mode(vid_mode),
		.cpu_rom_addr(cpu_rom_addr), .cpu_rom_do(cpu_rom_do),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wr(dl_wr),
		.snd_rq(snd_rq), .snd_no(snd_no)
	);

	// Program ROM contents depend on every address bit
	function automatic byte_t rom0_byte(input logic [14:0] a);
		rom0_byte = a[7:0] ^ {1'b0, a[14:8]} ^ 8'h3C;
	endfunction

	assign cpu_rom_do = rom0_byte(cpu_rom_addr);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_random(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic rand_byte(output byte_t b);
		logic [31:0] v;
		take_random(8, v);
		b = v[7:0];
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		assert (got === exp) else
			stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// Port rule for the low I/O addresses
	function automatic byte_t port_byte(input byte_t a, input inputs_t b);
		case (a[4:2])
			3'd0: port_byte = b.inp0;
			3'd1: port_byte = b.inp1;
			3'd2: port_byte = b.inp2;
			3'd3: port_byte = a[0] ? b.dsw1 : b.dsw0;
			3'd4: port_byte = b.dsw1;
			default: port_byte = 8'hFF;
		endcase
	endfunction

	// Enable period and request pulse width
	always @(negedge CLK48M) begin
		if (RESET) begin
			ce_gap = 0;
			ce_seen = 1'b0;
		end else begin
			ce_gap = ce_gap + 1;
			if (cpu_ce) begin
				assert (!ce_seen || ce_gap == 16) else
					stop_with_failure($sformatf("cpu_ce period was %0d cycles", ce_gap));
				ce_seen = 1'b1;
				ce_gap = 0;
			end
			assert (!(snd_rq && rq_prev)) else
				stop_with_failure("snd_rq stayed high for more than one cycle");
			if (snd_rq) begin
				rq_seen = rq_seen + 1;
			end
			rq_prev = snd_rq;
		end
	end

	// Wait for the cycle that follows an enable
	task automatic align_to_ce();
		do begin
			@(posedge CLK48M);
			#1;
		end while (!cpu_ce);
		@(posedge CLK48M);
		#1;
	endtask

	// One CPU bus cycle, starting in the cycle after an enable
	task automatic bus_cycle(input bit io, input bit wr, input cpu_addr_t a, input byte_t d,
		output byte_t di);
		cpu_bus.addr = a;
		cpu_bus.dout = d;
		cpu_bus.mreq = ~io;
		cpu_bus.iorq = io;
		cpu_bus.rd = ~wr;
		cpu_bus.wr = wr;
		do begin
			@(posedge CLK48M);
			#1;
		end while (!cpu_ce);
		di = cpu_di;
		assert (cpu_wr_out === (wr & ~io)) else
			stop_with_failure($sformatf("Mismatch cpu_wr_out: got %h expected %h",
				cpu_wr_out, wr & ~io));
		@(posedge CLK48M);
		#1;
		cpu_bus = '0;
	endtask

	task automatic read_check(input bit io, input cpu_addr_t a, input byte_t exp);
		byte_t di;
		bus_cycle(io, 1'b0, a, 8'h00, di);
		check_byte("cpu_di", di, exp);
	endtask

	initial begin
		#(TIMEOUT_NS);
		stop_with_failure("Watchdog expired before the tests finished");
	end

	initial begin
		byte_t d;
		byte_t di;
		logic [31:0] v;
		cpu_addr_t a;

		cpu_bus = '0;
		board_in = '0;
		vid_cs = 1'b0;
		vid_do = 8'h00;
		dl_addr = '0;
		dl_data = 8'h00;
		dl_wr = 1'b0;

		// Reset state
		@(negedge RESET);
		#2;
		check_byte("snd_rq", {7'b0, snd_rq}, 8'h00);
		check_byte("snd_no", snd_no, 8'h00);
		check_byte("vid_mode", vid_mode, 8'h00);
		check_byte("cpu_ce", {7'b0, cpu_ce}, 8'h00);

		take_random(32, v);
		board_in[39:8] = v;
		rand_byte(board_in.dsw1);
		align_to_ce();

		// Input ports and unmapped I/O
		for (int i = 0; i < 20; i++) begin
			read_check(1'b1, cpu_addr_t'(i), port_byte(byte_t'(i), board_in));
		end
		read_check(1'b1, 16'h001C, 8'hFF);

		// Work RAM
		for (int i = 0; i < 128; i++) begin
			take_random(12, v);
			a = 16'hC000 | cpu_addr_t'(v[11:0]);
			rand_byte(d);
			bus_cycle(1'b0, 1'b1, a, d, di);
			ram_model[a[11:0]] = d;
			ram_written.push_back(a);
		end
		for (int i = 0; i < 128; i++) begin
			take_random(7, v);
			a = ram_written[v[6:0]];
			read_check(1'b0, a, ram_model[a[11:0]]);
		end

		// Download into the banked ROM, then two writes outside its window
		dl_wr = 1'b1;
		for (int i = 0; i < 16384; i++) begin
			dl_addr = DL_ROM1_BASE + dl_addr_t'(i);
			rand_byte(dl_data);
			rom1_model[i] = dl_data;
			@(posedge CLK48M);
			#1;
		end
		dl_addr = 18'h07FFF;
		dl_data = ~rom1_model[16383];
		@(posedge CLK48M);
		#1;
		dl_addr = 18'h0C000;
		dl_data = ~rom1_model[0];
		@(posedge CLK48M);
		#1;
		dl_wr = 1'b0;
		align_to_ce();

		read_check(1'b0, 16'h8000, rom1_model[0]);
		read_check(1'b0, 16'hBFFF, rom1_model[16383]);
		for (int i = 0; i < 64; i++) begin
			take_random(14, v);
			read_check(1'b0, 16'h8000 | cpu_addr_t'(v[13:0]), rom1_model[v[13:0]]);
		end
		for (int i = 0; i < 32; i++) begin
			take_random(15, v);
			read_check(1'b0, cpu_addr_t'(v[14:0]), rom0_byte(v[14:0]));
		end

		// Video mode latch and its readback
		rand_byte(d);
		bus_cycle(1'b1, 1'b1, 16'h0015, d, di);
		check_byte("vid_mode", vid_mode, d);
		read_check(1'b1, 16'h0015, d);
		read_check(1'b1, 16'h0019, d);
		rand_byte(d);
		bus_cycle(1'b1, 1'b1, 16'h0019, d, di);
		check_byte("vid_mode", vid_mode, d);
		read_check(1'b1, 16'h0015, d);

		// Sound commands
		rand_byte(d);
		bus_cycle(1'b1, 1'b1, 16'h0014, d, di);
		rq_expected = rq_expected + 1;
		check_byte("snd_rq", {7'b0, snd_rq}, 8'h01);
		check_byte("snd_no", snd_no, d);
		rand_byte(d);
		bus_cycle(1'b1, 1'b1, 16'h0018, d, di);
		rq_expected = rq_expected + 1;
		check_byte("snd_rq", {7'b0, snd_rq}, 8'h01);
		check_byte("snd_no", snd_no, d);

		// External video window overrides every region
		vid_cs = 1'b1;
		for (int i = 0; i < 8; i++) begin
			rand_byte(vid_do);
			take_random(16, v);
			read_check(v[0], cpu_addr_t'(v[15:0]), vid_do);
		end
		vid_cs = 1'b0;

		// Open bus
		read_check(1'b0, 16'hE000, 8'hFF);
		read_check(1'b0, 16'hFFFF, 8'hFF);

		@(posedge CLK48M);
		#1;
		if (rq_seen != rq_expected) begin
			stop_with_failure($sformatf("snd_rq pulsed %0d times for %0d sound writes",
				rq_seen, rq_expected));
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/sys1_pkg.sv
hdl/main_bus_decoder.sv
hdl/input_port_mux.sv
hdl/work_ram.sv
hdl/download_rom.sv
hdl/io_latches.sv
hdl/cpu_data_select.sv
hdl/sys1_main_top.sv
tb/tb_clock_gen.sv
tb/sys1_main_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the System 1 main board simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f files.f \
	--top-module sys1_main_tb \
	--Mdir obj_dir \
	-o sys1_main_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sys1_main_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
